// ==== source/cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Memory depths in 16-bit words
`define CPU_IMEM_DEPTH 256
`define CPU_DMEM_DEPTH 256

// General registers, r0 reads as zero
`define CPU_NUM_REGS 16

`define CPU_RESET_PC 16'h0000

`endif

// ==== source/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    typedef enum logic [3:0] {
        ADD = 4'h0, SUB = 4'h1, XOR = 4'h2, SLL = 4'h3, SRA = 4'h4,
        LW  = 4'h8, SW  = 4'h9, LLB = 4'hA, LHB = 4'hB,
        B   = 4'hC, BR  = 4'hD, PCS = 4'hE, HLT = 4'hF
    } opcode_e;

    typedef struct packed {
        opcode_e    opcode;
        logic [3:0] rd;
        logic [3:0] rs;
        logic [3:0] rt;
    } r_fmt_t;

    typedef struct packed {
        opcode_e    opcode;
        logic [2:0] cond;
        logic [8:0] offset;
    } b_fmt_t;

    // Same word, register view or branch view
    typedef union packed {
        r_fmt_t r_fmt;
        b_fmt_t b_fmt;
    } inst_u;

    typedef struct packed {
        logic z;
        logic v;
        logic n;
    } flags_t;

    // flag_we bit order follows flags_t
    typedef struct packed {
        logic       rf_we;
        logic       mem_we;
        logic       mem_rd;
        logic [2:0] flag_we;
        logic       imm_src;
        logic       is_branch;
        logic       is_branch_reg;
        logic       is_pcs;
        logic       is_hlt;
    } ctrl_t;

    typedef struct packed {
        logic        valid;
        ctrl_t       ctrl;
        inst_u       inst;
        logic [15:0] pc;
        logic [15:0] op_a;
        logic [15:0] op_b;
        logic [3:0]  rs1;
        logic [3:0]  rs2;
    } idex_t;

    typedef struct packed {
        logic        valid;
        ctrl_t       ctrl;
        logic [3:0]  rd;
        logic [15:0] result;
        logic [15:0] store_data;
        flags_t      flags;
        logic [3:0]  store_src;
    } exmem_t;

    typedef struct packed {
        logic        valid;
        logic        rf_we;
        logic [3:0]  rd;
        logic [15:0] data;
        logic        is_hlt;
    } memwb_t;

    typedef struct packed {
        logic        valid;
        logic [3:0]  rd;
        logic [16-1:0] data;
    } wb_t;

    // First source register, zero when the opcode reads none
    function automatic logic [3:0] src_a(inst_u i);
        case (i.r_fmt.opcode)
            LLB, LHB:                            return i.r_fmt.rd;
            ADD, SUB, XOR, SLL, SRA, LW, SW, BR: return i.r_fmt.rs;
            default:                             return 4'h0;
        endcase
    endfunction

    // Second source, SW reads its data register here
    function automatic logic [3:0] src_b(inst_u i);
        case (i.r_fmt.opcode)
            ADD, SUB, XOR: return i.r_fmt.rt;
            SW:            return i.r_fmt.rd;
            default:       return 4'h0;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== source/control_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module control_unit (
    input  cpu_pkg::inst_u inst,
    output cpu_pkg::ctrl_t ctrl
);
    import cpu_pkg::*;

    always_comb begin
        ctrl = '0;
        case (inst.r_fmt.opcode)
            ADD, SUB: begin
                ctrl.rf_we   = 1'b1;
                ctrl.flag_we = 3'b111;
            end
            XOR: begin
                ctrl.rf_we   = 1'b1;
                ctrl.flag_we = 3'b100;
            end
            // Shift amount comes from the rt field
            SLL, SRA: begin
                ctrl.rf_we   = 1'b1;
                ctrl.flag_we = 3'b100;
                ctrl.imm_src = 1'b1;
            end
            LW: begin
                ctrl.rf_we   = 1'b1;
                ctrl.mem_rd  = 1'b1;
                ctrl.imm_src = 1'b1;
            end
            SW: begin
                ctrl.mem_we  = 1'b1;
                ctrl.imm_src = 1'b1;
            end
            LLB, LHB: begin
                ctrl.rf_we   = 1'b1;
                ctrl.imm_src = 1'b1;
            end
            B:   ctrl.is_branch = 1'b1;
            BR: begin
                ctrl.is_branch     = 1'b1;
                ctrl.is_branch_reg = 1'b1;
            end
            PCS: begin
                ctrl.rf_we  = 1'b1;
                ctrl.is_pcs = 1'b1;
            end
            HLT:     ctrl.is_hlt = 1'b1;
            default: ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/register_file.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "cpu_config.svh"

module register_file (
    input  logic         clk,
    input  logic         rst_n,
    input  logic [3:0]   rs1,
    input  logic [3:0]   rs2,
    input  cpu_pkg::wb_t wr,
    output logic [15:0]  rd1,
    output logic [15:0]  rd2
);
    logic [15:0] regs [`CPU_NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= 16'h0000;
            end
        end else if (wr.valid && wr.rd != 4'h0) begin
            regs[wr.rd] <= wr.data;
        end
    end

    // Write in the same cycle wins over the array
    function automatic logic [15:0] read_port(input logic [3:0] sel);
        if (sel == 4'h0) begin
            return 16'h0000;
        end
        if (wr.valid && wr.rd == sel) begin
            return wr.data;
        end
        return regs[sel];
    endfunction

    always_comb begin
        rd1 = read_port(rs1);
        rd2 = read_port(rs2);
    end

endmodule

`default_nettype wire

// ==== source/alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  cpu_pkg::opcode_e op,
    input  logic [15:0]      a,
    input  logic [15:0]      b,
    output logic [15:0]      result,
    output cpu_pkg::flags_t  flags
);
    import cpu_pkg::*;

    always_comb begin
        result  = 16'h0000;
        flags.v = 1'b0;
        case (op)
            ADD: begin
                result  = a + b;
                flags.v = (a[15] == b[15]) && (result[15] != a[15]);
            end
            SUB: begin
                result  = a - b;
                flags.v = (a[15] != b[15]) && (result[15] != a[15]);
            end
            XOR: result = a ^ b;
            SLL: result = a << b[3:0];
            SRA: result = $signed(a) >>> b[3:0];
            // Byte inserts keep the other half of rd
            LLB: result = {a[15:8], b[7:0]};
            LHB: result = {b[7:0], a[7:0]};
            default: result = 16'h0000;
        endcase
        flags.z = (result == 16'h0000);
        flags.n = result[15];
    end

endmodule

`default_nettype wire

// ==== source/hazard_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module hazard_unit (
    input  cpu_pkg::idex_t  idex,
    input  cpu_pkg::exmem_t exmem,
    input  cpu_pkg::memwb_t memwb,
    input  cpu_pkg::inst_u  id_inst,
    output logic [1:0]      fwd_a,
    output logic [1:0]      fwd_b,
    output logic [1:0]      fwd_br,
    output logic            fwd_store,
    output logic            stall
);
    import cpu_pkg::*;

    logic [3:0] id_src1;
    logic [3:0] id_src2;
    logic [3:0] ex_rd;
    logic       ex_alu_wr;
    logic       ex_load;
    logic       mem_wr;
    logic       mem_alu_wr;
    logic       wb_wr;

    // 01 picks the newer stage, 10 the older one
    function automatic logic [1:0] pick(
        input logic [3:0] src,
        input logic       newer_wr,
        input logic [3:0] newer_rd,
        input logic       older_wr,
        input logic [3:0] older_rd
    );
        if (src == 4'h0) begin
            return 2'b00;
        end
        if (newer_wr && newer_rd == src) begin
            return 2'b01;
        end
        if (older_wr && older_rd == src) begin
            return 2'b10;
        end
        return 2'b00;
    endfunction

    assign id_src1    = src_a(id_inst);
    assign id_src2    = src_b(id_inst);
    assign ex_rd      = idex.inst.r_fmt.rd;
    assign ex_alu_wr  = idex.valid && idex.ctrl.rf_we && !idex.ctrl.mem_rd;
    assign ex_load    = idex.valid && idex.ctrl.mem_rd;
    assign mem_wr     = exmem.valid && exmem.ctrl.rf_we;
    assign mem_alu_wr = mem_wr && !exmem.ctrl.mem_rd;
    assign wb_wr      = memwb.valid && memwb.rf_we;

    assign fwd_a = pick(idex.rs1, mem_alu_wr, exmem.rd, wb_wr, memwb.rd);
    assign fwd_b = pick(idex.rs2, mem_alu_wr, exmem.rd, wb_wr, memwb.rd);

    // BR register is read in ID, so EX and MEM are its later stages
    assign fwd_br = pick(id_inst.r_fmt.rs, ex_alu_wr, ex_rd, mem_wr, exmem.rd);

    assign fwd_store = exmem.valid && exmem.ctrl.mem_we && wb_wr &&
                       (exmem.store_src != 4'h0) && (memwb.rd == exmem.store_src);

    // src1 also covers a BR waiting on a load
    // Store data needs no stall, it is caught from WB in MEM
    assign stall = ex_load && (ex_rd != 4'h0) &&
                   ((ex_rd == id_src1) ||
                    ((ex_rd == id_src2) && (id_inst.r_fmt.opcode != SW)));

endmodule

`default_nettype wire

// ==== source/branch_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module branch_unit (
    input  cpu_pkg::inst_u  inst,
    input  logic [15:0]     pc,
    input  logic [15:0]     br_reg,
    input  cpu_pkg::flags_t flags,
    output logic            taken,
    output logic [15:0]     target
);
    import cpu_pkg::*;

    logic cond_met;

    always_comb begin
        case (inst.b_fmt.cond)
            3'd0:    cond_met = !flags.z;
            3'd1:    cond_met = flags.z;
            3'd2:    cond_met = !flags.z && !flags.n;
            3'd3:    cond_met = flags.n;
            3'd4:    cond_met = flags.z || !flags.n;
            3'd5:    cond_met = flags.n || flags.z;
            3'd6:    cond_met = flags.v;
            default: cond_met = 1'b1;
        endcase
    end

    assign taken = cond_met &&
                   ((inst.b_fmt.opcode == B) || (inst.b_fmt.opcode == BR));

    // Word offset relative to the next instruction
    assign target = (inst.b_fmt.opcode == BR) ? br_reg :
                    pc + 16'd2 + {{6{inst.b_fmt.offset[8]}}, inst.b_fmt.offset, 1'b0};

endmodule

`default_nettype wire

// ==== source/cpu.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "cpu_config.svh"

module cpu (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         imem_load,
    input  logic [7:0]   imem_addr,
    input  logic [15:0]  imem_data,
    output logic         hlt,
    output logic [15:0]  pc,
    output cpu_pkg::wb_t wb
);
    import cpu_pkg::*;

    localparam int IMEM_AW = $clog2(`CPU_IMEM_DEPTH);
    localparam int DMEM_AW = $clog2(`CPU_DMEM_DEPTH);

    logic [15:0] imem [`CPU_IMEM_DEPTH];
    logic [15:0] dmem [`CPU_DMEM_DEPTH];

    logic        ifid_valid;
    inst_u       ifid_inst;
    logic [15:0] ifid_pc;
    idex_t       idex, idex_d;
    exmem_t      exmem, exmem_d;
    memwb_t      memwb, memwb_d;
    flags_t      flag_q;
    logic        fetch_halted;
    logic        hlt_q;

    inst_u       id_inst;
    ctrl_t       id_ctrl_raw, id_ctrl;
    logic [3:0]  id_src1, id_src2;
    logic [15:0] id_rd1, id_rd2, id_br_reg, br_target;
    flags_t      id_flags;
    logic        br_taken, redirect, id_hlt, stall, fwd_store;
    logic [1:0]  fwd_a, fwd_b, fwd_br;

    logic [15:0] ex_a, ex_b_reg, ex_b, ex_imm, alu_result, ex_result;
    opcode_e     alu_op;
    flags_t      alu_flags;
    logic [DMEM_AW-1:0] mem_idx;
    logic [15:0] mem_store_data, mem_data;

    function automatic logic [15:0] fwd_mux(input logic [1:0] sel, input logic [15:0] newer,
                                            input logic [15:0] older, input logic [15:0] base);
        case (sel)
            2'b01:   return newer;
            2'b10:   return older;
            default: return base;
        endcase
    endfunction

    // Program load only while reset is held
    always_ff @(posedge clk) begin
        if (!rst_n && imem_load) begin
            imem[imem_addr] <= imem_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `CPU_RESET_PC;
        end else if (!stall && !fetch_halted && !id_hlt) begin
            pc <= redirect ? br_target : pc + 16'd2;
        end
    end

    // Taken branch or HLT in ID squashes the fetched word
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ifid_valid <= 1'b0;
        end else if (!stall) begin
            ifid_valid <= !(redirect || fetch_halted || id_hlt);
            ifid_inst  <= imem[pc[IMEM_AW:1]];
            ifid_pc    <= pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_halted <= 1'b0;
        end else if (id_hlt) begin
            fetch_halted <= 1'b1;
        end
    end

    assign id_inst = ifid_valid ? ifid_inst : '0;
    assign id_ctrl = ifid_valid ? id_ctrl_raw : '0;
    assign id_hlt  = id_ctrl.is_hlt;
    assign id_src1 = src_a(id_inst);
    assign id_src2 = src_b(id_inst);

    control_unit u_ctrl (.inst(id_inst), .ctrl(id_ctrl_raw));

    register_file u_rf (.clk(clk), .rst_n(rst_n), .rs1(id_src1), .rs2(id_src2),
                        .wr(wb), .rd1(id_rd1), .rd2(id_rd2));

    hazard_unit u_haz (.idex(idex), .exmem(exmem), .memwb(memwb), .id_inst(id_inst),
                       .fwd_a(fwd_a), .fwd_b(fwd_b), .fwd_br(fwd_br),
                       .fwd_store(fwd_store), .stall(stall));

    // Youngest flag writer per bit
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            if (idex.valid && idex.ctrl.flag_we[i]) begin
                id_flags[i] = alu_flags[i];
            end else if (exmem.valid && exmem.ctrl.flag_we[i]) begin
                id_flags[i] = exmem.flags[i];
            end else begin
                id_flags[i] = flag_q[i];
            end
        end
    end

    assign id_br_reg = id_ctrl.is_branch_reg ?
                       fwd_mux(fwd_br, ex_result, mem_data, id_rd1) : 16'h0000;

    branch_unit u_br (.inst(id_inst), .pc(ifid_pc), .br_reg(id_br_reg), .flags(id_flags),
                      .taken(br_taken), .target(br_target));

    assign redirect = id_ctrl.is_branch && br_taken && !stall;

    assign idex_d = '{valid: ifid_valid, ctrl: id_ctrl, inst: id_inst, pc: ifid_pc,
                      op_a: id_rd1, op_b: id_rd2, rs1: id_src1, rs2: id_src2};

    // Stall sends a bubble into EX
    always_ff @(posedge clk) begin
        if (!rst_n || stall) begin
            idex.valid <= 1'b0;
            idex.ctrl  <= '0;
        end else begin
            idex <= idex_d;
        end
    end

    assign ex_a     = fwd_mux(fwd_a, exmem.result, memwb.data, idex.op_a);
    assign ex_b_reg = fwd_mux(fwd_b, exmem.result, memwb.data, idex.op_b);

    always_comb begin
        case (idex.inst.r_fmt.opcode)
            SLL, SRA: ex_imm = {12'h000, idex.inst.r_fmt.rt};
            LW, SW:   ex_imm = {{11{idex.inst.r_fmt.rt[3]}}, idex.inst.r_fmt.rt, 1'b0};
            default:  ex_imm = {8'h00, idex.inst.r_fmt.rs, idex.inst.r_fmt.rt};
        endcase
    end

    assign ex_b   = idex.ctrl.imm_src ? ex_imm : ex_b_reg;
    assign alu_op = (idex.ctrl.mem_rd || idex.ctrl.mem_we) ? ADD : idex.inst.r_fmt.opcode;

    alu u_alu (.op(alu_op), .a(ex_a), .b(ex_b), .result(alu_result), .flags(alu_flags));

    assign ex_result = idex.ctrl.is_pcs ? idex.pc + 16'd2 : alu_result;

    assign exmem_d = '{valid: idex.valid, ctrl: idex.ctrl, rd: idex.inst.r_fmt.rd,
                       result: ex_result, store_data: ex_b_reg, flags: alu_flags,
                       store_src: idex.rs2};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exmem.valid <= 1'b0;
            exmem.ctrl  <= '0;
        end else begin
            exmem <= exmem_d;
        end
    end

    // Byte address, word index
    assign mem_idx        = exmem.result[DMEM_AW:1];
    assign mem_store_data = fwd_store ? memwb.data : exmem.store_data;
    assign mem_data       = exmem.ctrl.mem_rd ? dmem[mem_idx] : exmem.result;

    always_ff @(posedge clk) begin
        if (exmem.valid && exmem.ctrl.mem_we) begin
            dmem[mem_idx] <= mem_store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flag_q <= '0;
        end else if (exmem.valid) begin
            for (int i = 0; i < 3; i++) begin
                if (exmem.ctrl.flag_we[i]) begin
                    flag_q[i] <= exmem.flags[i];
                end
            end
        end
    end

    assign memwb_d = '{valid: exmem.valid, rf_we: exmem.ctrl.rf_we, rd: exmem.rd,
                       data: mem_data, is_hlt: exmem.ctrl.is_hlt};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            memwb.valid  <= 1'b0;
            memwb.rf_we  <= 1'b0;
            memwb.is_hlt <= 1'b0;
        end else begin
            memwb <= memwb_d;
        end
    end

    // r0 writes retire without a trace record
    assign wb.valid = memwb.valid && memwb.rf_we && (memwb.rd != 4'h0);
    assign wb.rd    = memwb.rd;
    assign wb.data  = memwb.data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hlt_q <= 1'b0;
        end else if (memwb.valid && memwb.is_hlt) begin
            hlt_q <= 1'b1;
        end
    end

    assign hlt = hlt_q || (memwb.valid && memwb.is_hlt);

endmodule

`default_nettype wire

// ==== tb/cpu_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_chk (
    input logic         clk,
    input logic         rst_n,
    input logic         hlt,
    input logic [15:0]  pc,
    input cpu_pkg::wb_t wb
);

    // Once halted the core stays halted
    hlt_sticky: assert property (@(posedge clk) disable iff (!rst_n) hlt |=> hlt)
        else $error("hlt fell after it had risen");

    hlt_pc_frozen: assert property (@(posedge clk) disable iff (!rst_n) hlt |=> $stable(pc))
        else $error("pc moved while hlt was high");

    wb_no_r0: assert property (@(posedge clk) disable iff (!rst_n) wb.valid |-> wb.rd != 4'h0)
        else $error("write-back to register 0");

    // First edge of reset still sees the unreset pipeline
    wb_quiet_reset: assert property (@(posedge clk) (!rst_n && !$past(rst_n)) |-> !wb.valid)
        else $error("write-back strobe during reset");

endmodule

`default_nettype wire

// ==== tb/cpu_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_tb;
    import cpu_pkg::*;

    localparam int NUM_TESTS = 5;

    logic        clk;
    logic        rst_n;
    logic        imem_load;
    logic [7:0]  imem_addr;
    logic [15:0] imem_data;
    logic        hlt;
    logic [15:0] pc;
    wb_t         wb;

    logic [7:0]  prog_addr [$];
    logic [15:0] prog_word [$];
    int          exp_test [$];
    logic [3:0]  exp_rd [$];
    logic [15:0] exp_data [$];
    logic [15:0] exp_pc;
    int          test_errs [1:NUM_TESTS];
    logic        reported [1:NUM_TESTS];
    int          seen;
    int          errors;
    int          cycles;
    int          limit;
    int          passed;
    int          failed;

    cpu dut (
        .clk(clk), .rst_n(rst_n), .imem_load(imem_load), .imem_addr(imem_addr),
        .imem_data(imem_data), .hlt(hlt), .pc(pc), .wb(wb)
    );

    bind cpu cpu_chk chk (.clk(clk), .rst_n(rst_n), .hlt(hlt), .pc(pc), .wb(wb));

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic string test_name(input int t);
        case (t)
            1:       return "alu forwarding chains";
            2:       return "load use and store forwarding";
            3:       return "conditional branches";
            4:       return "register branch and pcs";
            default: return "halt and final state";
        endcase
    endfunction

    task automatic read_golden();
        int          fd;
        int          n;
        int          t;
        logic [15:0] a;
        logic [15:0] b;
        string       line;
        fd = $fopen("tb/cpu_golden.txt", "r");
        if (fd == 0) begin
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.len() == 0) begin
                continue;
            end
            case (line.getc(0))
                "P": begin
                    n = $sscanf(line, "P %h %h", a, b);
                    // Byte address in the file, word index on the port
                    prog_addr.push_back(a[8:1]);
                    prog_word.push_back(b);
                end
                "W": begin
                    n = $sscanf(line, "W %d %h %h", t, a, b);
                    exp_test.push_back(t);
                    exp_rd.push_back(a[3:0]);
                    exp_data.push_back(b);
                end
                "E": n = $sscanf(line, "E %h", exp_pc);
                default: ;
            endcase
        end
        $fclose(fd);
    endtask

    // One word per cycle through the load strobe
    task automatic load_program();
        for (int i = 0; i < prog_word.size(); i++) begin
            @(posedge clk);
            #1;
            imem_load = 1'b1;
            imem_addr = prog_addr[i];
            imem_data = prog_word[i];
        end
        @(posedge clk);
        #1;
        imem_load = 1'b0;
    endtask

    task automatic report_test(input int t);
        reported[t] = 1'b1;
        if (test_errs[t] == 0) begin
            passed++;
            $display("test %0d %s: ok", t, test_name(t));
        end else begin
            failed++;
            $display("test %0d %s: %0d errors", t, test_name(t), test_errs[t]);
        end
    endtask

    task automatic check_record();
        int t;
        if (seen >= exp_data.size()) begin
            $display("** Error at %0t: unexpected write-back r%0d = %h",
                     $time, wb.rd, wb.data);
            test_errs[NUM_TESTS]++;
            errors++;
            return;
        end
        t = exp_test[seen];
        if (wb.rd != exp_rd[seen] || wb.data != exp_data[seen]) begin
            $display("** Error at %0t: record %0d is r%0d = %h, expected r%0d = %h",
                     $time, seen, wb.rd, wb.data, exp_rd[seen], exp_data[seen]);
            test_errs[t]++;
            errors++;
        end
        seen++;
        if (seen == exp_data.size() || exp_test[seen] != t) begin
            report_test(t);
        end
    endtask

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        if (rst_n && wb.valid) begin
            check_record();
        end
    end

    initial begin
        rst_n     = 1'b0;
        imem_load = 1'b0;
        imem_addr = 8'h00;
        imem_data = 16'h0000;
        exp_pc    = 16'h0000;
        seen      = 0;
        errors    = 0;
        cycles    = 0;
        passed    = 0;
        failed    = 0;
        for (int i = 1; i <= NUM_TESTS; i++) begin
            test_errs[i] = 0;
            reported[i]  = 1'b0;
        end
        read_golden();
        limit = 20 * prog_word.size() + 200;
        if (prog_word.size() == 0) begin
            $display("golden file tb/cpu_golden.txt is missing or holds no program");
            errors++;
        end else begin
            load_program();
            repeat (10) @(posedge clk);
            #1;
            rst_n = 1'b1;
            while (!hlt && cycles < limit) begin
                @(negedge clk);
                cycles++;
            end
            // Keep clocking the halted core for a few cycles
            repeat (4) @(negedge clk);
        end
        if (!hlt) begin
            $display("hlt did not rise within %0d cycles", limit);
            test_errs[NUM_TESTS]++;
            errors++;
        end else begin
            if (seen != exp_data.size()) begin
                $display("** Error at %0t: %0d write-back records, expected %0d",
                         $time, seen, exp_data.size());
                test_errs[NUM_TESTS]++;
                errors++;
            end
            if (pc != exp_pc) begin
                $display("** Error at %0t: final pc %h, expected %h", $time, pc, exp_pc);
                test_errs[NUM_TESTS]++;
                errors++;
            end
        end
        for (int t = 1; t < NUM_TESTS; t++) begin
            if (!reported[t]) begin
                $display("test %0d never retired all of its records", t);
                test_errs[t]++;
                errors++;
                report_test(t);
            end
        end
        report_test(NUM_TESTS);
        $display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== cpu.f ====
+incdir+source
source/cpu_pkg.sv
source/control_unit.sv
source/register_file.sv
source/alu.sv
source/hazard_unit.sv
source/branch_unit.sv
source/cpu.sv
tb/cpu_chk.sv
tb/cpu_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = cpu_tb
FILELIST = cpu.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== tb/cpu_golden.txt ====
# P byte-addr word : program word loaded into instruction memory
# W test rd data : expected write-back record in order, E pc : final pc
P 00 A105
P 02 A203
P 04 0312
P 06 1431
P 08 2543
P 0A 3654
P 0C B6F0
P 0E 4764
P 10 A820
P 12 9780
P 14 8980
P 16 0A91
P 18 8B80
P 1A 9B81
P 1C 8C81
P 1E 0DCA
P 20 9D8F
P 22 8E8F
P 24 1111
P 26 C201
P 28 AFEE
P 2A C001
P 2C AF11
P 2E 1321
P 30 C402
P 32 AFAA
P 34 AFBB
P 36 C601
P 38 A444
P 3A B57F
P 3C 0655
P 3E CC01
P 40 AFCC
P 42 E900
P 44 1AAA
P 46 AA50
P 48 DEA0
P 4A AFDD
P 4C AFDD
P 4E AFDD
P 50 EB00
P 52 D0B0
P 54 0CB2
P 56 F000
P 58 AFEE
W 1 1 0005
W 1 2 0003
W 1 3 0008
W 1 4 0003
W 1 5 000B
W 1 6 00B0
W 1 6 F0B0
W 1 7 FF0B
W 2 8 0020
W 2 9 FF0B
W 2 A FF10
W 2 B FF0B
W 2 C FF0B
W 2 D FE1B
W 2 E FE1B
W 3 1 0000
W 3 F 0011
W 3 3 0003
W 3 4 0044
W 3 5 7F0B
W 3 6 FE16
W 4 9 0044
W 4 A 0000
W 4 A 0050
W 4 B 0052
W 4 C 0055
E 0058
